//--- include/aud_config.svh
`ifndef AUD_CONFIG_SVH
`define AUD_CONFIG_SVH

// ==============================
// audio word geometry
// ==============================

// bits per channel word, sent msb first
`define AUD_SAMPLE_W 16

// bit position counter, one bit wider than needed for the word
`define AUD_CNT_W 5

`endif

//--- rtl/aud_pkg.sv
`default_nettype none

`include "aud_config.svh"

package aud_pkg;

    typedef enum logic [1:0] {
        ST_IDLE     = 2'd0,  // waiting for the lane phase
        ST_TRANSMIT = 2'd1,  // shifting out the word body
        ST_WAIT     = 2'd2   // word done, waiting for lrck to leave the phase
    } player_state_e;

    typedef enum logic {
        LANE_LEFT  = 1'b0,   // active while lrck is low
        LANE_RIGHT = 1'b1    // active while lrck is high
    } lane_e;

    typedef struct packed {
        logic [`AUD_SAMPLE_W-1:0] left;
        logic [`AUD_SAMPLE_W-1:0] right;
    } aud_frame_t;

endpackage

`default_nettype wire

//--- rtl/aud_player.sv
`timescale 1ns/1ps
`default_nettype none

`include "aud_config.svh"

module aud_player #(
    parameter aud_pkg::lane_e P_LANE = aud_pkg::LANE_LEFT
) (
    input  logic                     i_bclk,
    input  logic                     i_rst_n,
    input  logic                     i_en,
    input  logic                     i_daclrck,
    input  logic [`AUD_SAMPLE_W-1:0] i_sample,
    output logic                     o_bit,
    output logic                     o_busy,
    output logic                     o_done
);

    localparam int IDX_W    = $clog2(`AUD_SAMPLE_W);
    localparam int LAST_BIT = `AUD_SAMPLE_W - 1;
    localparam logic [`AUD_CNT_W-1:0] LAST_CNT = LAST_BIT[`AUD_CNT_W-1:0];

    aud_pkg::player_state_e state_r, state_w;
    logic [`AUD_CNT_W-1:0] count_r, count_w;
    logic                  bit_r, bit_w;
    logic                  done_r, done_w;
    logic                  lrck_phase;
    logic [IDX_W-1:0]      bit_idx;

    // the right lane owns lrck high, the left lane owns lrck low
    assign lrck_phase = (P_LANE == aud_pkg::LANE_RIGHT) ? i_daclrck : ~i_daclrck;

    assign bit_idx = ~count_r[IDX_W-1:0];  // counts down from the msb as count_r goes up

    // ==============================
    // next state
    // ==============================
    always_comb begin
        state_w = state_r;
        count_w = count_r;
        bit_w   = bit_r;
        done_w  = 1'b0;
        case (state_r)
            aud_pkg::ST_IDLE: begin
                count_w = '0;
                if (i_en && lrck_phase) begin
                    state_w = aud_pkg::ST_TRANSMIT;
                    count_w = {{(`AUD_CNT_W-1){1'b0}}, 1'b1};
                    bit_w   = i_sample[LAST_BIT];  // msb goes out on the start edge
                end
            end
            aud_pkg::ST_TRANSMIT: begin
                bit_w = i_sample[bit_idx];
                if (count_r == LAST_CNT) begin
                    state_w = aud_pkg::ST_WAIT;
                    count_w = '0;
                    done_w  = 1'b1;  // lsb is registered on this edge
                end else begin
                    count_w = count_r + 1'b1;
                end
            end
            aud_pkg::ST_WAIT: begin
                if (!lrck_phase) begin
                    state_w = aud_pkg::ST_IDLE;
                end
            end
            default: begin
                state_w = aud_pkg::ST_IDLE;
                count_w = '0;
            end
        endcase
    end

    // ==============================
    // registers
    // ==============================
    always_ff @(posedge i_bclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_r <= aud_pkg::ST_IDLE;
            count_r <= '0;
            bit_r   <= 1'b0;
            done_r  <= 1'b0;
        end else begin
            state_r <= state_w;
            count_r <= count_w;
            bit_r   <= bit_w;
            done_r  <= done_w;
        end
    end

    assign o_bit  = bit_r;   // line holds its last bit between words
    assign o_done = done_r;
    assign o_busy = (state_r == aud_pkg::ST_TRANSMIT) || done_r;

    // the word body must end at the lsb
    a_count_range: assert property (@(posedge i_bclk) disable iff (!i_rst_n)
        (state_r == aud_pkg::ST_TRANSMIT) |-> (count_r <= LAST_CNT))
        else $error("player bit counter ran past the last bit");

endmodule

`default_nettype wire

//--- rtl/aud_frame_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "aud_config.svh"

module aud_frame_ctrl (
    input  logic                     i_bclk,
    input  logic                     i_rst_n,
    input  logic                     i_ack,
    input  aud_pkg::aud_frame_t      i_frame,
    output logic                     o_req,
    output logic [`AUD_SAMPLE_W-1:0] o_left_sample,
    output logic [`AUD_SAMPLE_W-1:0] o_right_sample,
    input  logic                     i_left_bit,
    input  logic                     i_left_busy,
    input  logic                     i_right_bit,
    input  logic                     i_right_busy,
    input  logic                     i_right_done,
    output logic                     o_aud_dacdat,
    output logic                     o_underrun
);

    typedef enum logic [1:0] {
        REQ_IDLE    = 2'd0,  // waiting for ack low and an empty pending buffer
        REQ_ASSERT  = 2'd1,  // req high, waiting for ack
        REQ_RELEASE = 2'd2   // req dropped, waiting for ack low
    } req_state_e;

    req_state_e          req_state_r, req_state_w;
    logic                latch;
    aud_pkg::aud_frame_t pend_r;
    logic                pend_valid_r;
    aud_pkg::aud_frame_t active_r;
    logic                underrun_r;
    aud_pkg::lane_e      last_lane_r, sel_lane;

    // ==============================
    // four-phase request
    // ==============================
    always_comb begin
        req_state_w = req_state_r;
        case (req_state_r)
            REQ_IDLE: begin
                if (!i_ack && !pend_valid_r) begin
                    req_state_w = REQ_ASSERT;
                end
            end
            REQ_ASSERT: begin
                if (i_ack) begin
                    req_state_w = REQ_RELEASE;
                end
            end
            REQ_RELEASE: begin
                if (!i_ack) begin
                    req_state_w = REQ_IDLE;
                end
            end
            default: req_state_w = REQ_IDLE;
        endcase
    end

    always_ff @(posedge i_bclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            req_state_r <= REQ_IDLE;
        end else begin
            req_state_r <= req_state_w;
        end
    end

    assign o_req = (req_state_r == REQ_ASSERT);
    assign latch = (req_state_r == REQ_ASSERT) && i_ack;  // first cycle of ack only

    // ==============================
    // pending and active frames
    // ==============================
    always_ff @(posedge i_bclk) begin
        if (latch) begin
            pend_r <= i_frame;
        end
    end

    always_ff @(posedge i_bclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pend_valid_r <= 1'b0;
            active_r     <= '0;  // the first frame after reset plays silence
            underrun_r   <= 1'b0;
        end else begin
            if (latch) begin
                pend_valid_r <= 1'b1;
            end else if (i_right_done) begin
                pend_valid_r <= 1'b0;
            end
            if (i_right_done) begin
                if (pend_valid_r) begin
                    active_r <= pend_r;
                end else begin
                    active_r   <= '0;
                    underrun_r <= 1'b1;  // sticky until reset
                end
            end
        end
    end

    assign o_left_sample  = active_r.left;
    assign o_right_sample = active_r.right;
    assign o_underrun     = underrun_r;

    // ==============================
    // bit merge
    // ==============================
    always_comb begin
        if (i_left_busy) begin
            sel_lane = aud_pkg::LANE_LEFT;
        end else if (i_right_busy) begin
            sel_lane = aud_pkg::LANE_RIGHT;
        end else begin
            sel_lane = last_lane_r;  // keep the line on the lane that spoke last
        end
    end

    always_ff @(posedge i_bclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            last_lane_r <= aud_pkg::LANE_LEFT;
        end else begin
            last_lane_r <= sel_lane;
        end
    end

    assign o_aud_dacdat = (sel_lane == aud_pkg::LANE_RIGHT) ? i_right_bit : i_left_bit;

    a_req_after_ack_low: assert property (@(posedge i_bclk) disable iff (!i_rst_n)
        (i_ack && !o_req) |=> !o_req)
        else $error("o_req raised while i_ack is still high");

    // a latch on anything but the rising ack edge would consume one frame twice
    a_single_latch: assert property (@(posedge i_bclk) disable iff (!i_rst_n)
        latch |-> $rose(i_ack))
        else $error("frame latched twice in one handshake");

endmodule

`default_nettype wire

//--- rtl/aud_dac_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "aud_config.svh"

module aud_dac_if (
    input  logic                i_bclk,
    input  logic                i_rst_n,
    input  logic                i_daclrck,
    input  logic                i_en,
    output logic                o_req,
    input  logic                i_ack,
    input  aud_pkg::aud_frame_t i_frame,
    output logic                o_aud_dacdat,
    output logic                o_underrun
);

    logic [`AUD_SAMPLE_W-1:0] left_sample;
    logic [`AUD_SAMPLE_W-1:0] right_sample;
    logic                     left_bit, left_busy;
    logic                     right_bit, right_busy, right_done;

    // ==============================
    // channel players
    // ==============================
    aud_player #(.P_LANE(aud_pkg::LANE_LEFT)) u_left (
        .i_bclk    (i_bclk),
        .i_rst_n   (i_rst_n),
        .i_en      (i_en),
        .i_daclrck (i_daclrck),
        .i_sample  (left_sample),
        .o_bit     (left_bit),
        .o_busy    (left_busy),
        .o_done    ()              // frames are committed on the right word end
    );

    aud_player #(.P_LANE(aud_pkg::LANE_RIGHT)) u_right (
        .i_bclk    (i_bclk),
        .i_rst_n   (i_rst_n),
        .i_en      (i_en),
        .i_daclrck (i_daclrck),
        .i_sample  (right_sample),
        .o_bit     (right_bit),
        .o_busy    (right_busy),
        .o_done    (right_done)
    );

    aud_frame_ctrl u_ctrl (
        .i_bclk         (i_bclk),
        .i_rst_n        (i_rst_n),
        .i_ack          (i_ack),
        .i_frame        (i_frame),
        .o_req          (o_req),
        .o_left_sample  (left_sample),
        .o_right_sample (right_sample),
        .i_left_bit     (left_bit),
        .i_left_busy    (left_busy),
        .i_right_bit    (right_bit),
        .i_right_busy   (right_busy),
        .i_right_done   (right_done),
        .o_aud_dacdat   (o_aud_dacdat),
        .o_underrun     (o_underrun)
    );

endmodule

`default_nettype wire

//--- bench/tb_aud_dac_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "aud_config.svh"

module tb_aud_dac_if;

    localparam int NUM_SLOTS    = 24;
    localparam int PHASE_CYCLES = 32;
    localparam int RESET_CYCLES = 10;
    localparam int HOLD_REQ     = 3;   // this ack stays high across the next right word end
    localparam int HOLD_CYCLES  = 70;
    localparam int LATE_REQ     = 6;   // this request is answered after a right word end
    localparam int LATE_DELAY   = 80;
    localparam int EN_OFF_SLOT  = 14;
    localparam int MAX_CYCLES   = 40 * 2 * PHASE_CYCLES + 1440;
    localparam int RX_IDLE      = 0;
    localparam int RX_BODY      = 1;
    localparam int RX_WAIT      = 2;
    localparam int SRC_IDLE     = 0;
    localparam int SRC_WAIT     = 1;
    localparam int SRC_ACK      = 2;

    logic                i_bclk;
    logic                i_rst_n;
    logic                i_daclrck;
    logic                i_en;
    logic                o_req;
    logic                i_ack;
    aud_pkg::aud_frame_t i_frame;
    logic                o_aud_dacdat;
    logic                o_underrun;

    integer                   seed;
    int                       cyc;
    int                       lrck_cnt;
    int                       en_off_cycles;
    int                       src_state;
    int                       src_delay;
    int                       src_hold;
    int                       req_count;
    logic                     req_prev;
    aud_pkg::aud_frame_t      acked_q[$];
    int                       rx_state[2];  // index 0 is the left lane
    int                       rx_cnt[2];
    logic [`AUD_SAMPLE_W-1:0] rx_word[2];
    logic                     last_bit;
    int                       slot;
    int                       slot_src[$];  // ack index per frame slot, -1 plays silence
    int                       consumed;
    logic                     exp_underrun;

    aud_dac_if dut (
        .i_bclk       (i_bclk),
        .i_rst_n      (i_rst_n),
        .i_daclrck    (i_daclrck),
        .i_en         (i_en),
        .o_req        (o_req),
        .i_ack        (i_ack),
        .i_frame      (i_frame),
        .o_aud_dacdat (o_aud_dacdat),
        .o_underrun   (o_underrun)
    );

    initial begin
        i_bclk = 1'b0;
        forever #2 i_bclk = ~i_bclk;
    end

    initial begin
        seed          = 32'hb548_39a1;
        i_rst_n       = 1'b0;
        i_daclrck     = 1'b0;
        i_en          = 1'b1;
        i_ack         = 1'b0;
        i_frame       = '0;
        cyc           = 0;
        lrck_cnt      = 0;
        en_off_cycles = 0;
        src_state     = SRC_IDLE;
        src_delay     = 0;
        src_hold      = 0;
        req_count     = 0;
        req_prev      = 1'b0;
        rx_state[0]   = RX_IDLE;
        rx_state[1]   = RX_IDLE;
        rx_cnt[0]     = 0;
        rx_cnt[1]     = 0;
        last_bit      = 1'b0;
        slot          = 0;
        consumed      = 0;
        exp_underrun  = 1'b0;
        slot_src.push_back(-1);  // the first frame after reset is silence
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "value mismatch");
        end
    endtask

    // ==============================
    // reference model
    // ==============================
    function automatic logic [`AUD_SAMPLE_W-1:0] expected_word(input int src, input bit right);
        aud_pkg::aud_frame_t f;
        if (src < 0) begin
            return '0;
        end
        f = acked_q[src];
        return right ? f.right : f.left;
    endfunction

    // a right word end commits the pending frame, or silence when none was acknowledged
    task automatic commit_slot();
        if (consumed < acked_q.size()) begin
            slot_src.push_back(consumed);
            consumed++;
        end else begin
            slot_src.push_back(-1);
            exp_underrun = 1'b1;
        end
        slot++;
    endtask

    task automatic finish_word(input bit lane);
        check_value(32'(rx_word[lane]), 32'(expected_word(slot_src[slot], lane)),
                    $sformatf("slot %0d %s word", slot, lane ? "right" : "left"));
        check_value(32'(o_underrun), 32'(exp_underrun), "underrun flag");
        if (lane) begin
            commit_slot();
        end
    endtask

    // ==============================
    // receiver
    // ==============================
    task automatic receive_lane(input bit lane);
        logic phase;
        phase = lane ? i_daclrck : ~i_daclrck;  // levels seen at the last rising edge
        case (rx_state[lane])
            RX_IDLE: begin
                if (i_en && phase) begin
                    rx_state[lane] = RX_BODY;
                    rx_word[lane]  = {{(`AUD_SAMPLE_W-1){1'b0}}, o_aud_dacdat};
                    rx_cnt[lane]   = 1;
                    last_bit       = o_aud_dacdat;
                end
            end
            RX_BODY: begin
                rx_word[lane] = {rx_word[lane][`AUD_SAMPLE_W-2:0], o_aud_dacdat};
                rx_cnt[lane]++;
                last_bit = o_aud_dacdat;
                if (rx_cnt[lane] == `AUD_SAMPLE_W) begin
                    rx_state[lane] = RX_WAIT;
                    finish_word(lane);
                end
            end
            default: begin
                if (!phase) begin
                    rx_state[lane] = RX_IDLE;
                end
            end
        endcase
    endtask

    // ==============================
    // source model and stimulus
    // ==============================
    task automatic run_source();
        if (o_req && !req_prev) begin
            check_value(32'(i_ack), 32'd0, "i_ack level when o_req rose");
        end
        req_prev = o_req;
        if (src_state == SRC_IDLE && o_req) begin
            src_delay = (req_count == LATE_REQ) ? LATE_DELAY : {$random(seed)} % 6;
            src_hold  = (req_count == HOLD_REQ) ? HOLD_CYCLES : 0;
            req_count++;
            src_state = SRC_WAIT;
        end
        if (src_state == SRC_WAIT) begin
            if (src_delay == 0) begin
                i_frame = $random(seed);
                acked_q.push_back(i_frame);
                i_ack     = 1'b1;
                src_state = SRC_ACK;
            end else begin
                src_delay--;
            end
        end else if (src_state == SRC_ACK) begin
            check_value(32'(o_req), 32'd0, "o_req while i_ack is high");  // one latch per ack
            if (src_hold == 0) begin
                i_ack     = 1'b0;
                src_state = SRC_IDLE;
            end else begin
                src_hold--;
            end
        end
    endtask

    task automatic drive_lrck_en();
        lrck_cnt++;
        if (lrck_cnt == PHASE_CYCLES) begin
            lrck_cnt  = 0;
            i_daclrck = ~i_daclrck;
            if (!i_en && !i_daclrck && en_off_cycles >= PHASE_CYCLES) begin
                i_en = 1'b1;  // back on exactly at a left phase start
            end
        end
        if (!i_en) begin
            en_off_cycles++;
        end
        if (i_en && en_off_cycles == 0 && slot == EN_OFF_SLOT &&
            rx_state[1] == RX_BODY && rx_cnt[1] == 8) begin
            i_en = 1'b0;
        end
    endtask

    task automatic report_timeout();
        aud_pkg::player_state_e left_state;
        left_state = dut.u_left.state_r;
        $display("timeout: only %0d of %0d frames arrived in %0d cycles, left player in %s",
                 slot, NUM_SLOTS, cyc, left_state.name());
        $display("=== FAIL ===");
        $fatal(1, "simulation timed out");
    endtask

    task automatic end_run();
        $display("=== PASS ===");
        $finish;
    endtask

    always @(negedge i_bclk) begin
        cyc++;
        if (cyc >= MAX_CYCLES) begin
            report_timeout();
        end else if (!i_rst_n) begin
            check_value(32'(o_aud_dacdat), 32'd0, "dac data in reset");
            check_value(32'(o_underrun), 32'd0, "underrun in reset");
            check_value(32'(o_req), 32'd0, "o_req in reset");
            if (cyc == RESET_CYCLES) begin
                i_rst_n = 1'b1;
            end
        end else if (slot >= NUM_SLOTS) begin
            end_run();
        end else begin
            if (cyc == RESET_CYCLES + 1) begin
                check_value(32'(o_req), 32'd1, "o_req after first edge out of reset");
            end
            receive_lane(1'b0);
            receive_lane(1'b1);
            if (rx_state[0] != RX_BODY && rx_state[1] != RX_BODY) begin
                check_value(32'(o_aud_dacdat), 32'(last_bit), "line level between words");
            end
            run_source();
            drive_lrck_en();
        end
    end

endmodule

`default_nettype wire

//--- aud_dac_if.f
+incdir+include
rtl/aud_pkg.sv
rtl/aud_player.sv
rtl/aud_frame_ctrl.sv
rtl/aud_dac_if.sv
bench/tb_aud_dac_if.sv

//--- run_sim.sh
#!/bin/sh
# builds tb_aud_dac_if with verilator and runs it into sim.log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_aud_dac_if \
    -f aud_dac_if.f \
    -o tb_aud_dac_if
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_aud_dac_if > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "=== FAIL ===" "$LOG"; then
    echo "simulation reported a failure, see $LOG"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

echo "simulation finished without failures"
exit 0
